/* design/uart_pkg.sv */
`default_nettype none

package uart_pkg;

	localparam int CLK_FREQ_HZ  = 50_000_000;
	localparam int BAUD_RATE    = 3_125_000;
	localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE; // 16 clocks per bit

	localparam int DATA_BITS = 8;
	localparam int STOP_BITS = 2;
	localparam int FRAME_W   = DATA_BITS + 1; // start bit + data

	localparam int CNT_W     = $clog2(CLKS_PER_BIT);
	localparam int BIT_CNT_W = $clog2(DATA_BITS + 1);

	localparam logic [CNT_W-1:0] CNT_LAST      = CNT_W'(CLKS_PER_BIT - 1);
	// first running cycle stands for the half point, so count on from there
	localparam logic [CNT_W-1:0] CNT_HALF_NEXT = CNT_W'(CLKS_PER_BIT / 2 + 1);

	localparam logic [BIT_CNT_W-1:0] DATA_LAST = BIT_CNT_W'(DATA_BITS - 1);
	localparam logic [BIT_CNT_W-1:0] STOP_LAST = BIT_CNT_W'(STOP_BITS - 1);

	typedef logic [DATA_BITS-1:0] data_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	typedef enum logic [1:0] {
		SH_HOLD, // keep frame
		SH_LOAD, // start bit + data
		SH_NEXT  // shift down, fill with ones
	} shift_op_t;

	typedef struct packed {
		data_t data;
		logic  frame_err;
	} rx_word_t;

endpackage

`default_nettype wire

/* design/uart_baud_timer.sv */
`default_nettype none

module uart_baud_timer (
	input  wire  sys_clk,
	input  wire  sys_rst_n,
	input  wire  timer_run,
	input  wire  half_start,
	output logic bit_tick
);

	import uart_pkg::*;

	logic [CNT_W-1:0] cnt;

	// end of the current bit period
	assign bit_tick = timer_run && (cnt == CNT_LAST);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cnt <= '0;
		end else if (!timer_run) begin
			cnt <= '0; // parked while stopped
		end else if (bit_tick) begin
			cnt <= '0;
		end else if (half_start) begin
			cnt <= CNT_HALF_NEXT; // jump ahead, tick after half a bit
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/uart_tx_ctrl.sv */
`default_nettype none

module uart_tx_ctrl (
	input  wire                 sys_clk,
	input  wire                 sys_rst_n,
	input  wire                 tx_req,
	output logic                tx_busy,
	output logic                tx_done,
	output uart_pkg::shift_op_t shift_op
);

	import uart_pkg::*;

	tx_state_t             state;
	logic [BIT_CNT_W-1:0]  bit_cnt;
	logic                  timer_run;
	logic                  bit_tick;
	logic                  accept;

	uart_baud_timer u_tx_timer (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.timer_run  (timer_run),
		.half_start (1'b0),
		.bit_tick   (bit_tick)
	);

	assign tx_busy   = (state != TX_IDLE);
	assign timer_run = tx_busy;
	assign accept    = (state == TX_IDLE) && tx_req; // requests while busy are dropped

	// last cycle of the final stop bit
	assign tx_done = bit_tick && (state == TX_STOP) && (bit_cnt == STOP_LAST);

	always_comb begin
		if (accept)
			shift_op = SH_LOAD;
		else if (bit_tick)
			shift_op = SH_NEXT;
		else
			shift_op = SH_HOLD;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= TX_IDLE;
			bit_cnt <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					bit_cnt <= '0;
					if (accept)
						state <= TX_START;
				end
				TX_START: begin
					if (bit_tick) begin
						state   <= TX_DATA;
						bit_cnt <= '0;
					end
				end
				TX_DATA: begin
					if (bit_tick) begin
						if (bit_cnt == DATA_LAST) begin
							state   <= TX_STOP;
							bit_cnt <= '0;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				TX_STOP: begin
					if (bit_tick) begin
						if (bit_cnt == STOP_LAST) begin
							state   <= TX_IDLE; // tx_done this cycle
							bit_cnt <= '0;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				default: begin
					state   <= TX_IDLE;
					bit_cnt <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/uart_tx_shift.sv */
`default_nettype none

module uart_tx_shift (
	input  wire                      sys_clk,
	input  wire                      sys_rst_n,
	input  wire uart_pkg::shift_op_t shift_op,
	input  wire uart_pkg::data_t     tx_data,
	output logic                     tx
);

	import uart_pkg::*;

	// bit 0 is the line, start bit sits lowest after a load
	logic [FRAME_W-1:0] frame;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			frame <= '1; // line idles high
		end else begin
			case (shift_op)
				SH_LOAD:
					frame <= {tx_data, 1'b0};
				SH_NEXT:
					frame <= {1'b1, frame[FRAME_W-1:1]}; // ones become stop bits
				default:
					frame <= frame;
			endcase
		end
	end

	assign tx = frame[0];

endmodule

`default_nettype wire

/* design/uart_rx.sv */
`default_nettype none

module uart_rx (
	input  wire                sys_clk,
	input  wire                sys_rst_n,
	input  wire                rx,
	output logic               rx_valid,
	output uart_pkg::rx_word_t rx_word
);

	import uart_pkg::*;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP,
		RX_WAIT  // half bit past the stop sample
	} rx_state_t;

	rx_state_t            state;
	logic                 rx_meta;
	logic                 rx_sync;
	logic                 rx_prev;
	logic                 fall;
	logic                 half_q;
	logic                 timer_run;
	logic                 bit_tick;
	logic [BIT_CNT_W-1:0] bit_cnt;
	data_t                data_sr;
	logic                 err_q;

	// two-flop synchronizer plus one stage for edge detect
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign fall      = rx_prev && !rx_sync;
	assign timer_run = (state != RX_IDLE);

	uart_baud_timer u_rx_timer (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.timer_run  (timer_run),
		.half_start (half_q),
		.bit_tick   (bit_tick)
	);

	// payload shift register, lsb arrives first
	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA && bit_tick)
			data_sr <= {rx_sync, data_sr[DATA_BITS-1:1]};
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= RX_IDLE;
			bit_cnt  <= '0;
			half_q   <= 1'b0;
			err_q    <= 1'b0;
			rx_valid <= 1'b0;
			rx_word  <= '0;
		end else begin
			rx_valid <= 1'b0;
			half_q   <= 1'b0;
			case (state)
				RX_IDLE: begin
					bit_cnt <= '0;
					if (fall) begin
						state  <= RX_START;
						half_q <= 1'b1; // aim for mid start bit
					end
				end
				RX_START: begin
					if (bit_tick)
						state <= rx_sync ? RX_IDLE : RX_DATA; // glitch goes back
				end
				RX_DATA: begin
					if (bit_tick) begin
						if (bit_cnt == DATA_LAST) begin
							state   <= RX_STOP;
							bit_cnt <= '0;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				RX_STOP: begin
					if (bit_tick) begin
						err_q  <= !rx_sync; // first stop bit only
						state  <= RX_WAIT;
						half_q <= 1'b1;
					end
				end
				RX_WAIT: begin
					if (bit_tick) begin
						rx_word.data      <= data_sr;
						rx_word.frame_err <= err_q;
						rx_valid          <= 1'b1;
						state             <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/uart_top.sv */
`default_nettype none

module uart_top (
	input  wire                     sys_clk,
	input  wire                     sys_rst_n,
	input  wire                     tx_req,
	input  wire uart_pkg::data_t    tx_data,
	output wire                     tx_busy,
	output wire                     tx_done,
	output wire                     tx,
	input  wire                     rx,
	output wire                     rx_valid,
	output wire uart_pkg::rx_word_t rx_word
);

	import uart_pkg::*;

	shift_op_t shift_op; // ctrl to frame register

	uart_tx_ctrl u_tx_ctrl (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.shift_op  (shift_op)
	);

	uart_tx_shift u_tx_shift (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.shift_op  (shift_op),
		.tx_data   (tx_data),
		.tx        (tx)
	);

	// receive side is independent of the transmitter
	uart_rx u_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (rx),
		.rx_valid  (rx_valid),
		.rx_word   (rx_word)
	);

endmodule

`default_nettype wire

/* test/tb_uart_assert.sv */
`default_nettype none

module tb_uart_assert (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire tx_busy,
	input wire tx_done,
	input wire tx,
	input wire rx_valid
);

	int unsigned fire_cnt = 0;

	// line rests high between frames
	a_idle_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> tx)
	else begin
		$error("tx is low while the transmitter is idle");
		fire_cnt++;
	end

	a_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_done)
	else begin
		$error("tx_done held longer than one cycle");
		fire_cnt++;
	end

	a_valid_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_valid |=> !rx_valid)
	else begin
		$error("rx_valid high on two cycles in a row");
		fire_cnt++;
	end

	a_start_low: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(tx_busy) |-> !tx) // start bit with the first busy cycle
	else begin
		$error("no start bit when the transmitter went busy");
		fire_cnt++;
	end

endmodule

bind uart_top tb_uart_assert u_assert (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.tx_busy   (tx_busy),
	.tx_done   (tx_done),
	.tx        (tx),
	.rx_valid  (rx_valid)
);

`default_nettype wire

/* test/tb_uart.sv */
`default_nettype none

module tb_uart;

	import uart_pkg::*;

	localparam int FRAME_BITS     = 1 + DATA_BITS + STOP_BITS;
	localparam int FRAME_CYCLES   = FRAME_BITS * CLKS_PER_BIT;
	localparam int FB_W           = $clog2(FRAME_BITS);
	localparam int TEST_FRAMES    = 25; // frames sent or watched over all tests
	localparam int TIMEOUT_CYCLES = 2 * TEST_FRAMES * FRAME_CYCLES;

	logic     sys_clk = 1'b0;
	logic     sys_rst_n;
	logic     tx_req;
	data_t    tx_data;
	logic     tx_busy;
	logic     tx_done;
	logic     tx;
	logic     rx;
	logic     rx_valid;
	rx_word_t rx_word;
	logic     loop_sel; // 1 feeds tx back into rx
	logic     line_drv;

	int          errors    = 0;
	int          checks    = 0;
	int          cycle_cnt = 0;
	logic [31:0] seed;
	rx_word_t    rx_q[$];

	assign rx = loop_sel ? tx : line_drv;

	uart_top u_dut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_req    (tx_req),
		.tx_data   (tx_data),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.tx        (tx),
		.rx        (rx),
		.rx_valid  (rx_valid),
		.rx_word   (rx_word)
	);

	always #20 sys_clk = ~sys_clk;

	always @(negedge sys_clk) begin
		if (rx_valid)
			rx_q.push_back(rx_word); // keeps every received word in order
	end

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: simulation hung, stopped after %0d cycles", cycle_cnt);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic data_t rand_byte();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[23:16];
	endfunction

	// expected line level of bit idx within a frame
	function automatic logic frame_bit(input data_t d, input int idx);
		logic [FRAME_BITS-1:0] f;
		logic [FB_W-1:0]       sel;
		f   = {{STOP_BITS{1'b1}}, d, 1'b0};
		sel = FB_W'(idx);
		return f[sel];
	endfunction

	function automatic rx_word_t make_word(input data_t d, input logic err);
		rx_word_t w;
		w.data      = d;
		w.frame_err = err;
		return w;
	endfunction

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input rx_word_t exp, input rx_word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected data %h err %b, actual data %h err %b",
				name, exp.data, exp.frame_err, act.data, act.frame_err);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// returns on the falling edge right after the request cycle
	task automatic start_tx(input data_t d);
		@(negedge sys_clk);
		tx_req  = 1'b1;
		tx_data = d;
		@(negedge sys_clk);
		tx_req = 1'b0;
	endtask

	task automatic wait_tx_done();
		while (tx_done !== 1'b1)
			@(negedge sys_clk);
	endtask

	task automatic wait_rx(input int count, input int max_cycles);
		int n;
		n = 0;
		do begin
			@(posedge sys_clk);
			n++;
		end while (rx_q.size() < count && n < max_cycles);
	endtask

	task automatic test_reset();
		@(negedge sys_clk);
		check_bit("reset tx", 1'b1, tx);
		check_bit("reset tx_busy", 1'b0, tx_busy);
		check_bit("reset tx_done", 1'b0, tx_done);
		check_bit("reset rx_valid", 1'b0, rx_valid);
		check_word("reset rx_word", make_word('0, 1'b0), rx_word);
	endtask

	task automatic test_frame_shape();
		data_t d;
		d = rand_byte();
		rx_q.delete();
		start_tx(d);
		for (int k = 0; k < FRAME_CYCLES; k++) begin
			if (k % CLKS_PER_BIT == CLKS_PER_BIT / 2)
				check_bit("frame_shape tx", frame_bit(d, k / CLKS_PER_BIT), tx);
			// last cycle here is 176 cycles after the request
			check_bit("frame_shape tx_done", k == FRAME_CYCLES - 1, tx_done);
			@(negedge sys_clk);
		end
		check_bit("frame_shape tx_busy", 1'b0, tx_busy);
		wait_rx(1, FRAME_CYCLES);
		check_count("frame_shape words", 1, rx_q.size());
	endtask

	task automatic test_loopback();
		data_t sent[$];
		data_t d;
		rx_q.delete();
		for (int i = 0; i < 20; i++) begin
			d = rand_byte();
			sent.push_back(d);
			start_tx(d);
			wait_tx_done();
		end
		wait_rx(20, FRAME_CYCLES);
		check_count("loopback words", 20, rx_q.size());
		foreach (sent[i]) begin
			if (i < rx_q.size())
				check_word("loopback", make_word(sent[i], 1'b0), rx_q[i]);
		end
	endtask

	task automatic test_ignored_req();
		data_t a;
		int    dones;
		a     = rand_byte();
		dones = 0;
		rx_q.delete();
		start_tx(a);
		for (int k = 0; k < 2 * FRAME_CYCLES; k++) begin
			if (tx_done === 1'b1)
				dones++;
			tx_req = (k == FRAME_CYCLES / 2); // one strobe mid-frame
			if (k == FRAME_CYCLES / 2)
				tx_data = ~a;
			@(negedge sys_clk);
		end
		check_count("ignored_req tx_done count", 1, dones);
		check_bit("ignored_req tx_busy", 1'b0, tx_busy);
		wait_rx(1, FRAME_CYCLES);
		check_count("ignored_req words", 1, rx_q.size());
		if (rx_q.size() > 0)
			check_data("ignored_req data", a, rx_q[0].data);
	endtask

	task automatic test_framing_error();
		data_t d;
		d = rand_byte();
		@(negedge sys_clk);
		loop_sel = 1'b0;
		line_drv = 1'b1;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		rx_q.delete();
		for (int b = 0; b < FRAME_BITS; b++) begin
			line_drv = (b == 1 + DATA_BITS) ? 1'b0 : frame_bit(d, b); // first stop low
			repeat (CLKS_PER_BIT) @(negedge sys_clk);
		end
		line_drv = 1'b1;
		wait_rx(1, FRAME_CYCLES);
		check_count("framing_error words", 1, rx_q.size());
		if (rx_q.size() > 0)
			check_word("framing_error", make_word(d, 1'b1), rx_q[0]);
	endtask

	task automatic test_false_start();
		@(negedge sys_clk);
		rx_q.delete();
		line_drv = 1'b0;
		repeat (CLKS_PER_BIT / 4) @(negedge sys_clk);
		line_drv = 1'b1;
		repeat (FRAME_CYCLES) @(negedge sys_clk);
		@(posedge sys_clk);
		check_count("false_start words", 0, rx_q.size());
	endtask

	initial begin
		int assert_fails;
		sys_rst_n = 1'b0;
		tx_req    = 1'b0;
		tx_data   = '0;
		loop_sel  = 1'b1;
		line_drv  = 1'b1;
		seed      = 32'd3541;
		repeat (3) @(negedge sys_clk);
		sys_rst_n = 1'b1;

		test_reset();
		test_frame_shape();
		test_loopback();
		test_ignored_req();
		test_framing_error();
		test_false_start();

		assert_fails = int'(u_dut.u_assert.fire_cnt);
		$display("summary: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
design/uart_pkg.sv
design/uart_baud_timer.sv
design/uart_tx_ctrl.sv
design/uart_tx_shift.sv
design/uart_rx.sv
design/uart_top.sv
test/tb_uart_assert.sv
test/tb_uart.sv

/* Makefile */
TOP := tb_uart
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -F -q '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
